//--- execStage.f
rtl/rvTypesPkg.sv
rtl/execOpPkg.sv
rtl/intAlu.sv
rtl/branchUnit.sv
rtl/mulDivUnit.sv
rtl/execControl.sv
rtl/execStage.sv
tests/execStageTb.sv

//--- rtl/branchUnit.sv
// combinational; no compressed ops, so the link value is always pc + 4
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input  execOpPkg::branchCond_e cond,
    input  rvTypesPkg::addr_t      pc,
    input  rvTypesPkg::word_t      imm,
    input  rvTypesPkg::word_t      rs1Value,
    input  rvTypesPkg::word_t      rs2Value,
    output logic                   taken,
    output rvTypesPkg::addr_t      target,
    output rvTypesPkg::word_t      linkValue
);
    import rvTypesPkg::*;
    import execOpPkg::*;

    addr_t jalrSum;

    always_comb begin
        unique case (cond)
            CondEq:   taken = rs1Value == rs2Value;
            CondNe:   taken = rs1Value != rs2Value;
            CondLt:   taken = $signed(rs1Value) < $signed(rs2Value);
            CondGe:   taken = $signed(rs1Value) >= $signed(rs2Value);
            CondLtu:  taken = rs1Value < rs2Value;
            CondGeu:  taken = rs1Value >= rs2Value;
            // jumps are unconditional
            default:  taken = 1'b1;
        endcase
    end

    assign jalrSum = rs1Value + imm;

    // jalr drops bit 0 of the computed address
    assign target = (cond == CondJalr) ? {jalrSum[XLEN-1:1], 1'b0} : pc + imm;

    assign linkValue = pc + word_t'(4);

endmodule

`default_nettype wire

//--- rtl/execControl.sv
// one op in flight at most; writeback never stalls; inOp must hold while inValid && !inReady
`timescale 1ns/1ps
`default_nettype none

module execControl (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    input  execOpPkg::execOp_t     inOp,
    output logic                   inReady,
    output execOpPkg::aluCmd_e     aluCmd,
    output rvTypesPkg::word_t      aluSrc1,
    output rvTypesPkg::word_t      aluSrc2,
    input  rvTypesPkg::word_t      aluResult,
    input  logic                   branchTaken,
    input  rvTypesPkg::addr_t      branchTarget,
    input  rvTypesPkg::word_t      linkValue,
    output logic                   mdReq,
    output execOpPkg::mulDivReq_t  mdReqData,
    input  logic                   mdAck,
    input  rvTypesPkg::word_t      mdResult,
    output logic                   outValid,
    output execOpPkg::execResult_t outResult
);
    import rvTypesPkg::*;
    import execOpPkg::*;

    typedef enum logic [1:0] {Ready, Request, Release} ctrlState_e;

    ctrlState_e state;
    ctrlState_e stateNext;
    logic       accept;
    logic       isMulDiv;
    logic       mdDone;
    regIdx_t    mdRd;

    // ready again as soon as the unit has dropped ack
    assign inReady = (state == Ready) || (state == Release && !mdAck);
    assign accept = inValid && inReady;
    assign isMulDiv = inOp.unit == UnitMulDiv;
    assign mdReq = state == Request;
    assign mdDone = (state == Request) && mdAck;

    assign aluCmd = inOp.aluCmd;

    always_comb begin
        unique case (inOp.aluSrc1)
            Src1Pc:  aluSrc1 = inOp.pc;
            Src1Reg: aluSrc1 = inOp.rs1Value;
            default: aluSrc1 = '0;
        endcase
        unique case (inOp.aluSrc2)
            Src2Imm: aluSrc2 = inOp.imm;
            Src2Reg: aluSrc2 = inOp.rs2Value;
            default: aluSrc2 = '0;
        endcase
    end

    always_comb begin
        stateNext = state;
        unique case (state)
            Ready:   stateNext = (accept && isMulDiv) ? Request : Ready;
            Request: stateNext = mdAck ? Release : Request;
            Release: begin
                if (!mdAck) begin
                    stateNext = (accept && isMulDiv) ? Request : Ready;
                end
            end
            default: stateNext = Ready;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Ready;
            outValid <= 1'b0;
        end else begin
            state <= stateNext;
            outValid <= (accept && !isMulDiv) || mdDone;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && isMulDiv) begin
            mdReqData.cmd <= inOp.mulDivCmd;
            mdReqData.src1 <= inOp.rs1Value;
            mdReqData.src2 <= inOp.rs2Value;
            mdRd <= inOp.rd;
        end
        if (accept && !isMulDiv) begin
            outResult.rd <= inOp.rd;
            outResult.value <= (inOp.unit == UnitBranch) ? linkValue : aluResult;
            outResult.redirect <= (inOp.unit == UnitBranch) && branchTaken;
            outResult.target <= (inOp.unit == UnitBranch) ? branchTarget : '0;
        end else if (mdDone) begin
            outResult.rd <= mdRd;
            outResult.value <= mdResult;
            outResult.redirect <= 1'b0;
            outResult.target <= '0;
        end
    end

    // the unit needs several cycles, so no mul/div result shows two cycles after its accept
    assert property (@(posedge clk) disable iff (!arstN) (accept && isMulDiv) |-> ##2 !outValid);

endmodule

`default_nettype wire

//--- rtl/execOpPkg.sv
// execute stage encodings; integer ops only, no FP, CSR, load/store or trap fields
`default_nettype none

package execOpPkg;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluClear1,
        AluClear2
    } aluCmd_e;

    typedef enum logic [1:0] {UnitAlu, UnitBranch, UnitMulDiv} execUnit_e;

    typedef enum logic [2:0] {
        CondEq,
        CondNe,
        CondLt,
        CondGe,
        CondLtu,
        CondGeu,
        CondJal,
        CondJalr
    } branchCond_e;

    typedef enum logic [1:0] {MdMul, MdMulhu, MdDivu, MdRemu} mulDivCmd_e;

    typedef enum logic [1:0] {Src1Zero, Src1Pc, Src1Reg} aluSrc1_e;
    typedef enum logic [1:0] {Src2Zero, Src2Imm, Src2Reg} aluSrc2_e;

    // one decoded op with its operands already read from the register file
    typedef struct packed {
        execUnit_e          unit;
        aluCmd_e            aluCmd;
        aluSrc1_e           aluSrc1;
        aluSrc2_e           aluSrc2;
        branchCond_e        branchCond;
        mulDivCmd_e         mulDivCmd;
        rvTypesPkg::regIdx_t rd;
        rvTypesPkg::addr_t  pc;
        rvTypesPkg::word_t  imm;
        rvTypesPkg::word_t  rs1Value;
        rvTypesPkg::word_t  rs2Value;
    } execOp_t;

    typedef struct packed {
        mulDivCmd_e        cmd;
        rvTypesPkg::word_t src1;
        rvTypesPkg::word_t src2;
    } mulDivReq_t;

    // target is meaningful only while redirect is set
    typedef struct packed {
        rvTypesPkg::regIdx_t rd;
        rvTypesPkg::word_t   value;
        logic                redirect;
        rvTypesPkg::addr_t   target;
    } execResult_t;

endpackage

`default_nettype wire

//--- rtl/execStage.sv
// integer execute stage; bitsPerCycle sets mul/div speed (1, 2 or 4), no bypass or flush
`timescale 1ns/1ps
`default_nettype none

module execStage #(
    parameter int bitsPerCycle = 1
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    input  execOpPkg::execOp_t     inOp,
    output logic                   inReady,
    output logic                   outValid,
    output execOpPkg::execResult_t outResult
);
    import rvTypesPkg::*;
    import execOpPkg::*;

    aluCmd_e    aluCmd;
    word_t      aluSrc1;
    word_t      aluSrc2;
    word_t      aluResult;
    logic       branchTaken;
    addr_t      branchTarget;
    word_t      linkValue;
    logic       mdReq;
    mulDivReq_t mdReqData;
    logic       mdAck;
    word_t      mdResult;

    execControl control (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .inOp(inOp),
        .inReady(inReady),
        .aluCmd(aluCmd),
        .aluSrc1(aluSrc1),
        .aluSrc2(aluSrc2),
        .aluResult(aluResult),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .linkValue(linkValue),
        .mdReq(mdReq),
        .mdReqData(mdReqData),
        .mdAck(mdAck),
        .mdResult(mdResult),
        .outValid(outValid),
        .outResult(outResult)
    );

    intAlu alu (
        .cmd(aluCmd),
        .src1(aluSrc1),
        .src2(aluSrc2),
        .result(aluResult)
    );

    // branch compares read the op straight from the input
    branchUnit branch (
        .cond(inOp.branchCond),
        .pc(inOp.pc),
        .imm(inOp.imm),
        .rs1Value(inOp.rs1Value),
        .rs2Value(inOp.rs2Value),
        .taken(branchTaken),
        .target(branchTarget),
        .linkValue(linkValue)
    );

    mulDivUnit #(
        .bitsPerCycle(bitsPerCycle)
    ) mulDiv (
        .clk(clk),
        .arstN(arstN),
        .req(mdReq),
        .reqData(mdReqData),
        .ack(mdAck),
        .result(mdResult)
    );

endmodule

`default_nettype wire

//--- rtl/intAlu.sv
// purely combinational; shift amounts use src2[4:0], unknown commands return zero
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  execOpPkg::aluCmd_e cmd,
    input  rvTypesPkg::word_t  src1,
    input  rvTypesPkg::word_t  src2,
    output rvTypesPkg::word_t  result
);
    import rvTypesPkg::*;
    import execOpPkg::*;

    shamt_t shamt;

    assign shamt = src2[4:0];

    always_comb begin
        unique case (cmd)
            AluAdd:    result = src1 + src2;
            AluSub:    result = src1 - src2;
            AluSll:    result = src1 << shamt;
            AluSlt:    result = word_t'($signed(src1) < $signed(src2));
            AluSltu:   result = word_t'(src1 < src2);
            AluXor:    result = src1 ^ src2;
            AluSrl:    result = src1 >> shamt;
            // sign bit shifted in
            AluSra:    result = word_t'($signed(src1) >>> shamt);
            AluOr:     result = src1 | src2;
            AluAnd:    result = src1 & src2;
            AluClear1: result = src1 & ~src2;
            AluClear2: result = ~src1 & src2;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mulDivUnit.sv
// unsigned only (MUL, MULHU, DIVU, REMU); bitsPerCycle must divide 32; no flush once started
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit #(
    parameter int bitsPerCycle = 1
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   req,
    input  execOpPkg::mulDivReq_t  reqData,
    output logic                   ack,
    output rvTypesPkg::word_t      result
);
    import rvTypesPkg::*;
    import execOpPkg::*;

    localparam int Steps = XLEN / bitsPerCycle;

    typedef enum logic [1:0] {Idle, Busy, Done, WaitLow} mdState_e;

    mdState_e            state;
    logic [$clog2(XLEN):0] count;
    mulDivCmd_e          cmd;
    word_t               operand;
    logic [2*XLEN-1:0]   acc;
    logic [2*XLEN-1:0]   accNext;
    logic [XLEN:0]       sum;
    logic                isMul;

    assign isMul = cmd inside {MdMul, MdMulhu};

    // bitsPerCycle steps per clock
    // mul shifts {hi, lo} right and adds the multiplicand into hi when lo[0] is set
    // div shifts {rem, quot} left and keeps the trial subtract when it does not borrow
    always_comb begin
        accNext = acc;
        sum = '0;
        for (int i = 0; i < bitsPerCycle; i++) begin
            if (isMul) begin
                sum = {1'b0, accNext[2*XLEN-1:XLEN]} + (accNext[0] ? {1'b0, operand} : '0);
                accNext = {sum, accNext[XLEN-1:1]};
            end else begin
                sum = accNext[2*XLEN-1:XLEN-1] - {1'b0, operand};
                if (sum[XLEN]) begin
                    accNext = {accNext[2*XLEN-2:0], 1'b0};
                end else begin
                    accNext = {sum[XLEN-1:0], accNext[XLEN-2:0], 1'b1};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            count <= '0;
        end else begin
            unique case (state)
                Idle: begin
                    if (req) begin
                        state <= Busy;
                        count <= '0;
                    end
                end
                Busy: begin
                    count <= count + 1'b1;
                    if (count == ($clog2(XLEN) + 1)'(Steps - 1)) begin
                        state <= Done;
                    end
                end
                Done: begin
                    if (!req) begin
                        state <= WaitLow;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && req) begin
            cmd <= reqData.cmd;
            operand <= reqData.src2;
            acc <= {{XLEN{1'b0}}, reqData.src1};
        end else if (state == Busy) begin
            acc <= accNext;
        end
    end

    assign ack = state == Done;

    // a zero divisor leaves the quotient all ones and the remainder equal to the dividend
    assign result = (cmd inside {MdMul, MdDivu}) ? acc[XLEN-1:0] : acc[2*XLEN-1:XLEN];

    // requester has to wait for ack before it lets go
    assert property (@(posedge clk) disable iff (!arstN) (state == Busy) |-> req);

    assert property (@(posedge clk) disable iff (!arstN) $rose(ack) |-> req);

endmodule

`default_nettype wire

//--- rtl/rvTypesPkg.sv
// widths below are fixed at XLEN = 32 for RV32 and are not meant to be changed
`default_nettype none

package rvTypesPkg;

    localparam int XLEN = 32;

    // data word and instruction address share the register width
    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;

    // x0..x31
    typedef logic [4:0] regIdx_t;

    // only the low five bits of a shift operand count on RV32
    typedef logic [4:0] shamt_t;

endpackage

`default_nettype wire

//--- tests/execStageTb.sv
// checks results in order against reference models; mul/div timing is checked only via inReady
`timescale 1ns/1ps
`default_nettype none

module execStageTb;
    import rvTypesPkg::*;
    import execOpPkg::*;

    localparam int BitsPerCycle = 2;
    localparam int ResetCycles = 5;

    logic        clk;
    logic        arstN;
    logic        inValid;
    execOp_t     inOp;
    logic        inReady;
    logic        outValid;
    execResult_t outResult;

    execOp_t     ops[$];
    word_t       expValue[$];
    logic        expRedirect[$];
    addr_t       expTarget[$];
    int          acceptEdge[$];
    int          cycle = 0;
    int          timeoutLimit = 1000000;
    int          nAccepted = 0;
    int          doneCount = 0;
    logic [31:0] lfsr = 32'ha779;

    execStage #(
        .bitsPerCycle(BitsPerCycle)
    ) dut (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .inOp(inOp),
        .inReady(inReady),
        .outValid(outValid),
        .outResult(outResult)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            failRun("value check failed");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randWord(output word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsrNext(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t aluModel(input aluCmd_e c, input word_t a, input word_t b);
        int          sh;
        logic [63:0] ext;
        sh = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (c)
            AluAdd:    return a + b;
            AluSub:    return a - b;
            AluSll:    return a << sh;
            // signs differ, so the negative one is smaller
            AluSlt:    return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            AluSltu:   return word_t'(a < b);
            AluXor:    return a ^ b;
            AluSrl:    return a >> sh;
            AluSra:    return ext[31:0];
            AluOr:     return a | b;
            AluAnd:    return a & b;
            AluClear1: return a & ~b;
            default:   return ~a & b;
        endcase
    endfunction

    function automatic logic condHolds(input execOp_t op);
        word_t a;
        word_t b;
        a = op.rs1Value;
        b = op.rs2Value;
        case (op.branchCond)
            CondEq:  return a == b;
            CondNe:  return a != b;
            CondLt:  return (a[31] != b[31]) ? a[31] : a < b;
            CondGe:  return (a[31] != b[31]) ? b[31] : a >= b;
            CondLtu: return a < b;
            CondGeu: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t mulDivModel(input mulDivCmd_e c, input word_t a, input word_t b);
        logic [63:0] prod;
        prod = {32'h0, a} * {32'h0, b};
        case (c)
            MdMul:   return prod[31:0];
            MdMulhu: return prod[63:32];
            MdDivu:  return (b == 0) ? 32'hFFFF_FFFF : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic execOp_t aluOp(input aluCmd_e c, input aluSrc1_e s1, input aluSrc2_e s2,
                                      input addr_t pc, input word_t imm,
                                      input word_t rs1, input word_t rs2);
        execOp_t op;
        op = '0;
        op.unit = UnitAlu;
        op.aluCmd = c;
        op.aluSrc1 = s1;
        op.aluSrc2 = s2;
        op.pc = pc;
        op.imm = imm;
        op.rs1Value = rs1;
        op.rs2Value = rs2;
        return op;
    endfunction

    function automatic execOp_t branchOp(input branchCond_e c, input addr_t pc, input word_t imm,
                                         input word_t rs1, input word_t rs2);
        execOp_t op;
        op = aluOp(AluAdd, Src1Zero, Src2Zero, pc, imm, rs1, rs2);
        op.unit = UnitBranch;
        op.branchCond = c;
        return op;
    endfunction

    function automatic execOp_t mulDivOp(input mulDivCmd_e c, input word_t rs1, input word_t rs2);
        execOp_t op;
        op = aluOp(AluAdd, Src1Zero, Src2Zero, '0, '0, rs1, rs2);
        op.unit = UnitMulDiv;
        op.mulDivCmd = c;
        return op;
    endfunction

    // expected result is worked out per unit and pushed onto the table
    task automatic addEntry(input execOp_t opIn);
        execOp_t op;
        word_t   a;
        word_t   b;
        word_t   val;
        logic    red;
        addr_t   tgt;
        op = opIn;
        op.rd = regIdx_t'(ops.size() % 31 + 1);
        red = 1'b0;
        tgt = '0;
        a = (op.aluSrc1 == Src1Pc) ? op.pc : (op.aluSrc1 == Src1Reg) ? op.rs1Value : '0;
        b = (op.aluSrc2 == Src2Imm) ? op.imm : (op.aluSrc2 == Src2Reg) ? op.rs2Value : '0;
        case (op.unit)
            UnitAlu: val = aluModel(op.aluCmd, a, b);
            UnitBranch: begin
                val = op.pc + 4;
                red = condHolds(op);
                tgt = (op.branchCond == CondJalr) ? (op.rs1Value + op.imm) & ~32'h1
                                                  : op.pc + op.imm;
            end
            default: val = mulDivModel(op.mulDivCmd, op.rs1Value, op.rs2Value);
        endcase
        ops.push_back(op);
        expValue.push_back(val);
        expRedirect.push_back(red);
        expTarget.push_back(tgt);
    endtask

    task automatic buildTable();
        word_t a;
        word_t b;
        addEntry(aluOp(AluAdd, Src1Reg, Src2Imm, '0, 32'hFFFF_FFFD, 32'd5, '0));
        addEntry(aluOp(AluSub, Src1Reg, Src2Reg, '0, '0, 32'd3, 32'd10));
        addEntry(aluOp(AluSll, Src1Reg, Src2Reg, '0, '0, 32'h1, 32'h25));
        addEntry(aluOp(AluSlt, Src1Reg, Src2Reg, '0, '0, 32'hFFFF_FFFF, 32'd1));
        addEntry(aluOp(AluSltu, Src1Reg, Src2Reg, '0, '0, 32'hFFFF_FFFF, 32'd1));
        addEntry(aluOp(AluSrl, Src1Reg, Src2Reg, '0, '0, 32'h8000_0000, 32'd33));
        addEntry(aluOp(AluSra, Src1Reg, Src2Reg, '0, '0, 32'hF000_0000, 32'd4));
        addEntry(aluOp(AluSra, Src1Reg, Src2Imm, '0, 32'h3F, 32'h8000_0001, '0));
        addEntry(aluOp(AluAdd, Src1Pc, Src2Imm, 32'h1000, 32'h20, '0, '0));
        addEntry(aluOp(AluOr, Src1Zero, Src2Imm, '0, 32'h1234_5000, '0, '0));
        for (int i = 0; i < 12; i++) begin
            randWord(a);
            randWord(b);
            addEntry(aluOp(aluCmd_e'(i), Src1Reg, Src2Reg, '0, '0, a, b));
        end
        addEntry(branchOp(CondEq, 32'h200, 32'h40, 32'd7, 32'd7));
        addEntry(branchOp(CondNe, 32'h200, 32'h40, 32'd7, 32'd7));
        addEntry(branchOp(CondLt, 32'h204, 32'hFFFF_FFF0, 32'hFFFF_FFFE, 32'd1));
        addEntry(branchOp(CondGe, 32'h208, 32'h80, 32'hFFFF_FFFE, 32'd1));
        addEntry(branchOp(CondLtu, 32'h20C, 32'h80, 32'hFFFF_FFFE, 32'd1));
        addEntry(branchOp(CondGeu, 32'h210, 32'h100, 32'hFFFF_FFFE, 32'd1));
        addEntry(branchOp(CondJal, 32'h300, 32'hFFFF_FFF0, '0, '0));
        addEntry(branchOp(CondJalr, 32'h304, 32'h10, 32'h1001, '0));
        // ALU op right behind a mul waits at the input
        randWord(a);
        randWord(b);
        addEntry(mulDivOp(MdMul, a, b));
        addEntry(aluOp(AluXor, Src1Reg, Src2Reg, '0, '0, a, b));
        addEntry(mulDivOp(MdMulhu, a, b));
        randWord(a);
        randWord(b);
        addEntry(mulDivOp(MdDivu, a, b >> 12));
        addEntry(mulDivOp(MdRemu, a, b >> 12));
        addEntry(mulDivOp(MdDivu, a, '0));
        addEntry(mulDivOp(MdRemu, a, '0));
        addEntry(mulDivOp(MdDivu, 32'd100, 32'd7));
        addEntry(aluOp(AluAnd, Src1Reg, Src2Imm, '0, 32'hFF, a, '0));
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > timeoutLimit) begin
            failRun("timeout: not all results came back in time");
        end
    end

    // results must come back in acceptance order
    always @(posedge clk) begin
        if (arstN && outValid) begin
            if (doneCount >= nAccepted) begin
                failRun("outValid was high with no accepted op pending");
            end
            checkValue("outResult.rd", outResult.rd, ops[doneCount].rd);
            checkValue("outResult.value", outResult.value, expValue[doneCount]);
            checkValue("outResult.redirect", outResult.redirect, expRedirect[doneCount]);
            if (expRedirect[doneCount]) begin
                checkValue("outResult.target", outResult.target, expTarget[doneCount]);
            end
            if (ops[doneCount].unit != UnitMulDiv) begin
                checkValue("outValid latency", cycle - acceptEdge[doneCount], 1);
            end
            doneCount <= doneCount + 1;
        end
    end

    initial begin
        arstN = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        buildTable();
        timeoutLimit = ops.size() * (XLEN / BitsPerCycle + 8) + ResetCycles;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        checkValue("outValid", outValid, 1'b0);
        checkValue("inReady", inReady, 1'b1);
        for (int j = 0; j < ops.size(); j++) begin
            inValid <= 1'b1;
            inOp <= ops[j];
            @(posedge clk);
            while (!inReady) @(posedge clk);
            acceptEdge.push_back(cycle);
            // inReady low until the mul/div result was out
            if (j > 0 && ops[j-1].unit == UnitMulDiv) begin
                checkValue("results out before accept", doneCount, j);
            end
            nAccepted <= j + 1;
        end
        inValid <= 1'b0;
        while (doneCount < ops.size()) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
